// File: design/clk_gate.sv
////////////////////////////////////////////////////////////
// glitch-free clock gate cell
// latch based with a DFT test enable override
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module clk_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  // latched enable
  logic en_latch;

  // transparent while clk low
  // an enable change at a rising edge only shows on the next pulse
  always_latch begin
    if (!clk_i) begin
      // test enable forces the gate open
      en_latch <= en_i | test_en_i;
    end
  end

  // enable is stable for the whole high phase
  assign clk_o = clk_i & en_latch;

endmodule

// File: design/clk_mgr.sv
////////////////////////////////////////////////////////////
// clock manager top level
// root sequencing with settle timer, software registers
// and one gate cell per output clock
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module clk_mgr (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  test_en_i,
  input  logic                  ip_clk_en_i,
  output logic                  roots_en_o,
  input  clk_mgr_pkg::reg_req_t reg_req_i,
  output clk_mgr_pkg::reg_rsp_t reg_rsp_o,
  input  clk_mgr_pkg::idle_t    idle_i,
  output clk_mgr_pkg::clk_out_t clocks_o
);

  // root gate level and acknowledge
  logic root_en;
  logic roots_en;

  // timer handshake
  logic timer_load;
  logic timer_done;

  // group enables from the register block
  logic peri_sw_en;
  logic aes_en;
  logic hmac_en;

  // gate cell outputs
  logic clk_infra;
  logic clk_peri;
  logic clk_aes;
  logic clk_hmac;

  ////////////////////////////////////////////////////////////
  // root sequencing
  ////////////////////////////////////////////////////////////

  clk_root_fsm u_root_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ip_clk_en_i  (ip_clk_en_i),
    .timer_done_i (timer_done),
    .timer_load_o (timer_load),
    .root_en_o    (root_en),
    .roots_en_o   (roots_en)
  );

  clk_settle_timer u_settle_timer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (timer_load),
    .done_o (timer_done)
  );

  assign roots_en_o = roots_en;

  ////////////////////////////////////////////////////////////
  // software control
  ////////////////////////////////////////////////////////////

  clk_mgr_regs u_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .reg_req_i  (reg_req_i),
    .reg_rsp_o  (reg_rsp_o),
    .idle_i     (idle_i),
    .root_en_i  (root_en),
    .roots_en_i (roots_en),
    .peri_en_o  (peri_sw_en),
    .aes_en_o   (aes_en),
    .hmac_en_o  (hmac_en)
  );

  ////////////////////////////////////////////////////////////
  // gate cells
  ////////////////////////////////////////////////////////////

  // infra follows the root alone
  clk_gate u_infra_cg (
    .clk_i     (clk_i),
    .en_i      (root_en),
    .test_en_i (test_en_i),
    .clk_o     (clk_infra)
  );

  // direct software enable under the root
  clk_gate u_peri_cg (
    .clk_i     (clk_i),
    .en_i      (peri_sw_en & root_en),
    .test_en_i (test_en_i),
    .clk_o     (clk_peri)
  );

  // hint groups, busy already folded in
  clk_gate u_aes_cg (
    .clk_i     (clk_i),
    .en_i      (aes_en & root_en),
    .test_en_i (test_en_i),
    .clk_o     (clk_aes)
  );

  clk_gate u_hmac_cg (
    .clk_i     (clk_i),
    .en_i      (hmac_en & root_en),
    .test_en_i (test_en_i),
    .clk_o     (clk_hmac)
  );

  assign clocks_o.clk_infra = clk_infra;
  assign clocks_o.clk_peri  = clk_peri;
  assign clocks_o.clk_aes   = clk_aes;
  assign clocks_o.clk_hmac  = clk_hmac;

endmodule

// File: design/clk_mgr_pkg.sv
////////////////////////////////////////////////////////////
// clock manager shared definitions
// settle timing, register map, request and response
// structs, idle status and gated clock bundle
////////////////////////////////////////////////////////////

package clk_mgr_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // cycles the root must stay stable before the acknowledge moves
  localparam int unsigned SETTLE_CYCLES = 6;
  // wide enough to hold SETTLE_CYCLES
  localparam int unsigned SETTLE_W = $clog2(SETTLE_CYCLES + 1);
  // software register data width
  localparam int unsigned REG_DW = 8;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // root gate sequencing states
  typedef enum logic [1:0] {
    ST_OFF       = 2'd0,
    ST_RAMP_UP   = 2'd1,
    ST_ON        = 2'd2,
    ST_RAMP_DOWN = 2'd3
  } root_state_e;

  // register map
  // enables and hints are read/write, the two status words read only
  typedef enum logic [1:0] {
    ADDR_ENABLES      = 2'd0,
    ADDR_HINTS        = 2'd1,
    ADDR_HINTS_STATUS = 2'd2,
    ADDR_ROOT_STATUS  = 2'd3
  } reg_addr_e;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  // single cycle request strobe
  typedef struct packed {
    logic              valid;
    logic              write;
    reg_addr_e         addr;
    logic [REG_DW-1:0] wdata;
  } reg_req_t;

  // read data one cycle after the request
  typedef struct packed {
    logic              rvalid;
    logic [REG_DW-1:0] rdata;
  } reg_rsp_t;

  // accelerator busy status, high when idle
  typedef struct packed {
    logic aes_idle;
    logic hmac_idle;
  } idle_t;

  // gated clock outputs
  typedef struct packed {
    logic clk_infra;
    logic clk_peri;
    logic clk_aes;
    logic clk_hmac;
  } clk_out_t;

endpackage

// File: design/clk_mgr_regs.sv
////////////////////////////////////////////////////////////
// clock manager software registers
// peripheral enable and accelerator hints, effective
// hint enables and root status readback
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module clk_mgr_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  clk_mgr_pkg::reg_req_t reg_req_i,
  output clk_mgr_pkg::reg_rsp_t reg_rsp_o,
  input  clk_mgr_pkg::idle_t    idle_i,
  input  logic                  root_en_i,
  input  logic                  roots_en_i,
  output logic                  peri_en_o,
  output logic                  aes_en_o,
  output logic                  hmac_en_o
);

  import clk_mgr_pkg::*;

  // request decode
  logic wr_en;
  logic rd_en;

  // peripheral enable, bit 0 of ADDR_ENABLES
  logic       peri_en_q;
  // hints, bit 0 aes and bit 1 hmac
  logic [1:0] hints_q;

  // effective accelerator enables
  logic aes_en;
  logic hmac_en;

  // read path
  logic              rvalid_q;
  logic [REG_DW-1:0] rdata_d;
  logic [REG_DW-1:0] rdata_q;

  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign rd_en = reg_req_i.valid & ~reg_req_i.write;

  ////////////////////////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////////////////////////

  // status addresses have no write path
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      peri_en_q <= 1'b0;
      hints_q   <= 2'b00;
    end else if (wr_en) begin
      if (reg_req_i.addr == ADDR_ENABLES) begin
        peri_en_q <= reg_req_i.wdata[0];
      end
      if (reg_req_i.addr == ADDR_HINTS) begin
        hints_q <= reg_req_i.wdata[1:0];
      end
    end
  end

  // busy accelerator keeps its clock regardless of hint
  assign aes_en  = hints_q[0] | ~idle_i.aes_idle;
  assign hmac_en = hints_q[1] | ~idle_i.hmac_idle;

  ////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    case (reg_req_i.addr)
      ADDR_ENABLES:      rdata_d[0]   = peri_en_q;
      ADDR_HINTS:        rdata_d[1:0] = hints_q;
      ADDR_HINTS_STATUS: rdata_d[1:0] = {hmac_en, aes_en};
      ADDR_ROOT_STATUS:  rdata_d[1:0] = {root_en_i, roots_en_i};
      default:           rdata_d      = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  // data only captured on a read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rsp_o.rvalid = rvalid_q;
  assign reg_rsp_o.rdata  = rdata_q;

  assign peri_en_o = peri_en_q;
  assign aes_en_o  = aes_en;
  assign hmac_en_o = hmac_en;

  // rvalid exactly one cycle after each read, never otherwise
  rvalid_follows_read_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_en |=> reg_rsp_o.rvalid);
  rvalid_only_after_read_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_rsp_o.rvalid |-> $past(rd_en));

endmodule

// File: design/clk_root_fsm.sv
////////////////////////////////////////////////////////////
// root clock sequencer
// opens and closes the root gate on the power manager
// request and moves the acknowledge once the timer settles
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module clk_root_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ip_clk_en_i,
  input  logic timer_done_i,
  output logic timer_load_o,
  output logic root_en_o,
  output logic roots_en_o
);

  import clk_mgr_pkg::*;

  root_state_e state_q, state_d;

  // root gate level and acknowledge
  logic root_en_q, root_en_d;
  logic roots_en_q, roots_en_d;
  logic load;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    root_en_d  = root_en_q;
    roots_en_d = roots_en_q;
    load       = 1'b0;

    unique case (state_q)
      ST_OFF: begin
        // gate opens on the sampling edge
        if (ip_clk_en_i) begin
          state_d   = ST_RAMP_UP;
          root_en_d = 1'b1;
          load      = 1'b1;
        end
      end
      ST_RAMP_UP: begin
        // ramp always completes, request ignored here
        if (timer_done_i) begin
          state_d    = ST_ON;
          roots_en_d = 1'b1;
        end
      end
      ST_ON: begin
        if (!ip_clk_en_i) begin
          state_d   = ST_RAMP_DOWN;
          root_en_d = 1'b0;
          load      = 1'b1;
        end
      end
      ST_RAMP_DOWN: begin
        if (timer_done_i) begin
          state_d    = ST_OFF;
          roots_en_d = 1'b0;
        end
      end
      default: begin
        state_d = ST_OFF;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state and outputs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_OFF;
      root_en_q  <= 1'b0;
      roots_en_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      root_en_q  <= root_en_d;
      roots_en_q <= roots_en_d;
    end
  end

  // load goes out on the edge that enters a ramp
  assign timer_load_o = load;
  assign root_en_o    = root_en_q;
  assign roots_en_o   = roots_en_q;

  // acknowledge only moves once the timer has settled
  ack_after_done_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $changed(roots_en_o) |-> $past(timer_done_i));

  // never acknowledge a closed root
  ack_implies_root_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((state_q == ST_ON) && roots_en_o) |-> root_en_o);

endmodule

// File: design/clk_settle_timer.sv
////////////////////////////////////////////////////////////
// root settle timer
// loadable down-counter, pulses done once the root gate
// has been stable for SETTLE_CYCLES cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module clk_settle_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic load_i,
  output logic done_o
);

  import clk_mgr_pkg::*;

  // zero means idle
  logic [SETTLE_W-1:0] cnt_q;
  logic                done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      // one cycle pulse on the last step down to zero
      done_q <= (cnt_q == SETTLE_W'(1));
      if (load_i) begin
        cnt_q <= SETTLE_W'(SETTLE_CYCLES);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign done_o = done_q;

  // a new ramp must not start before the previous one settled
  load_while_busy_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_i |-> (cnt_q == '0));

endmodule

// File: run.sh
#!/bin/sh
# build and run the clock manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_clk_mgr \
  -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/tb_clk_mgr.sv
////////////////////////////////////////////////////////////
// clock manager testbench
// random register and idle stimulus against a model,
// root latency checks and gated clock edge counting
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clk_mgr;

  import clk_mgr_pkg::*;

  // run length
  localparam int N_ITER  = 24;
  localparam int WIN_LEN = 16;
  // one iteration stays under three windows, ten more for the fixed phases
  localparam int TIMEOUT_CYCLES = (N_ITER + 10) * 3 * WIN_LEN;

  logic     clk_i;
  logic     rst_ni;
  logic     test_en;
  logic     ip_clk_en;
  logic     roots_en;
  reg_req_t req;
  reg_rsp_t rsp;
  idle_t    idle;
  clk_out_t clocks;

  // model of software registers and root
  logic       m_peri;
  logic [1:0] m_hints;
  logic       m_root_en;
  logic       m_roots_en;

  integer seed;
  int     cycles = 0;
  int     n_checks = 0;
  int     n_mismatch = 0;
  int     n_other = 0;

  // edge counting
  logic clk_infra_w;
  logic clk_peri_w;
  logic clk_aes_w;
  logic clk_hmac_w;
  logic counting = 1'b0;
  int   cnt_infra;
  int   cnt_peri;
  int   cnt_aes;
  int   cnt_hmac;

  clk_mgr dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .test_en_i   (test_en),
    .ip_clk_en_i (ip_clk_en),
    .roots_en_o  (roots_en),
    .reg_req_i   (req),
    .reg_rsp_o   (rsp),
    .idle_i      (idle),
    .clocks_o    (clocks)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // hard limit on run length
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  assign clk_infra_w = clocks.clk_infra;
  assign clk_peri_w  = clocks.clk_peri;
  assign clk_aes_w   = clocks.clk_aes;
  assign clk_hmac_w  = clocks.clk_hmac;

  // gated edges land near posedge, counting toggles at negedge
  always @(posedge clk_infra_w) begin
    if (counting) cnt_infra++;
  end
  always @(posedge clk_peri_w) begin
    if (counting) cnt_peri++;
  end
  always @(posedge clk_aes_w) begin
    if (counting) cnt_aes++;
  end
  always @(posedge clk_hmac_w) begin
    if (counting) cnt_hmac++;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_logic(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_mismatch++;
      $display("Mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_rdata(input string name, input logic [REG_DW-1:0] exp,
                             input logic [REG_DW-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_mismatch++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      n_mismatch++;
      $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // set field means a full window of edges, clear means none
  task automatic check_clk_out(input string name, input clk_out_t exp_on);
    check_count({name, " clk_infra"}, exp_on.clk_infra ? WIN_LEN : 0, cnt_infra);
    check_count({name, " clk_peri"}, exp_on.clk_peri ? WIN_LEN : 0, cnt_peri);
    check_count({name, " clk_aes"}, exp_on.clk_aes ? WIN_LEN : 0, cnt_aes);
    check_count({name, " clk_hmac"}, exp_on.clk_hmac ? WIN_LEN : 0, cnt_hmac);
  endtask

  ////////////////////////////////////////////////////////////
  // model
  ////////////////////////////////////////////////////////////

  function automatic logic [REG_DW-1:0] model_rdata(input reg_addr_e addr);
    logic [REG_DW-1:0] d;
    d = '0;
    case (addr)
      ADDR_ENABLES: d[0] = m_peri;
      ADDR_HINTS: d[1:0] = m_hints;
      // busy accelerator overrides its hint
      ADDR_HINTS_STATUS: begin
        d[0] = m_hints[0] | ~idle.aes_idle;
        d[1] = m_hints[1] | ~idle.hmac_idle;
      end
      ADDR_ROOT_STATUS: begin
        d[0] = m_roots_en;
        d[1] = m_root_en;
      end
      default: d = '0;
    endcase
    return d;
  endfunction

  // every group sits under the root, test enable opens all
  function automatic clk_out_t model_clocks();
    clk_out_t c;
    c.clk_infra = m_root_en | test_en;
    c.clk_peri  = (m_peri & m_root_en) | test_en;
    c.clk_aes   = ((m_hints[0] | ~idle.aes_idle) & m_root_en) | test_en;
    c.clk_hmac  = ((m_hints[1] | ~idle.hmac_idle) & m_root_en) | test_en;
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus tasks, all entered on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic reg_write(input reg_addr_e addr, input logic [REG_DW-1:0] data);
    req.valid = 1'b1;
    req.write = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(negedge clk_i);
    req.valid = 1'b0;
    req.write = 1'b0;
    // a write gives no read response
    check_logic("write rvalid", 1'b0, rsp.rvalid);
    // status words have no write path
    if (addr == ADDR_ENABLES) m_peri = data[0];
    if (addr == ADDR_HINTS) m_hints = data[1:0];
  endtask

  task automatic read_check(input string name, input reg_addr_e addr);
    logic [REG_DW-1:0] exp;
    exp = model_rdata(addr);
    req.valid = 1'b1;
    req.write = 1'b0;
    req.addr  = addr;
    @(negedge clk_i);
    req.valid = 1'b0;
    // response one cycle after the request
    check_logic({name, " rvalid"}, 1'b1, rsp.rvalid);
    check_rdata({name, " ", addr.name()}, exp, rsp.rdata);
  endtask

  task automatic read_all(input string name);
    read_check(name, ADDR_ENABLES);
    read_check(name, ADDR_HINTS);
    read_check(name, ADDR_HINTS_STATUS);
    read_check(name, ADDR_ROOT_STATUS);
  endtask

  task automatic count_window();
    // quiet cycles so the last enable change reached the latches
    repeat (2) @(negedge clk_i);
    cnt_infra = 0;
    cnt_peri  = 0;
    cnt_aes   = 0;
    cnt_hmac  = 0;
    counting  = 1'b1;
    repeat (WIN_LEN) @(negedge clk_i);
    counting  = 1'b0;
  endtask

  task automatic ramp_root(input string name, input logic on);
    int n;
    ip_clk_en = on;
    // sampling edge is cycle zero
    @(negedge clk_i);
    n = 0;
    while (roots_en !== on && n < 4 * SETTLE_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    if (roots_en !== on) begin
      n_other++;
      $display("%s: roots_en_o never reached %b within %0d cycles", name, on, n);
    end else begin
      check_count({name, " latency"}, SETTLE_CYCLES + 1, n);
    end
    m_root_en  = on;
    m_roots_en = on;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    reg_addr_e   a;
    seed       = 38;
    rst_ni     = 1'b0;
    test_en    = 1'b0;
    ip_clk_en  = 1'b0;
    req        = '0;
    idle       = '1;
    m_peri     = 1'b0;
    m_hints    = 2'b00;
    m_root_en  = 1'b0;
    m_roots_en = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_logic("reset roots_en", 1'b0, roots_en);
    check_logic("reset rvalid", 1'b0, rsp.rvalid);
    read_all("reset");
    // root closed, nothing toggles
    count_window();
    check_clk_out("before root", model_clocks());

    ramp_root("ramp up", 1'b1);
    read_all("root on");

    for (int i = 0; i < N_ITER; i++) begin
      r = $random(seed);
      reg_write(ADDR_ENABLES, r[REG_DW-1:0]);
      r = $random(seed);
      reg_write(ADDR_HINTS, r[REG_DW-1:0]);
      r = $random(seed);
      idle.aes_idle  = r[0];
      idle.hmac_idle = r[1];
      // stray write to a status word
      if (r[2]) begin
        a = r[3] ? ADDR_ROOT_STATUS : ADDR_HINTS_STATUS;
        reg_write(a, r[15:8]);
      end
      count_window();
      check_clk_out("gating", model_clocks());
      repeat (4) begin
        r = $random(seed);
        a = reg_addr_e'(r[1:0]);
        read_check("readback", a);
      end
    end

    // groups open so the root alone closes them
    reg_write(ADDR_ENABLES, 8'h01);
    reg_write(ADDR_HINTS, 8'h03);
    ramp_root("ramp down", 1'b0);
    count_window();
    check_clk_out("root off", model_clocks());
    read_all("root off");

    test_en = 1'b1;
    count_window();
    check_clk_out("test enable", model_clocks());
    test_en = 1'b0;

    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch + n_other == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
design/clk_mgr_pkg.sv
design/clk_gate.sv
design/clk_settle_timer.sv
design/clk_root_fsm.sv
design/clk_mgr_regs.sv
design/clk_mgr.sv
sim/tb_clk_mgr.sv
